//--- files.f
source/video_pkg.sv
source/wb_mem_port.sv
source/sram_bank.sv
source/video_memory.sv
source/scanout.sv
source/video_subsystem.sv
testbench/video_subsystem_chk.sv
testbench/video_subsystem_tb.sv

//--- testbench/video_subsystem_tb.sv
`timescale 1ns/1ps

module video_subsystem_tb;
	import video_pkg::*;

	localparam int MEM_WORDS = 2048;
	localparam int LINE_WORDS = 32;
	localparam int TAG_SHIFT = 13;
	localparam int ACK_TIMEOUT = 16;
	localparam int STREAM_TIMEOUT = 64;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	bus_addr_t wb_adr;
	sel_t wb_sel;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;
	logic scan_enable;
	logic pixel_ready;
	word_t pixel_data;
	logic pixel_valid;
	logic line_start;
	logic frame_start;

	word_t model [MEM_WORDS];
	string cur_test;
	int test_errors;
	int pass_count;
	int fail_count;
	int stream_k;

	video_subsystem DUT (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.scan_enable(scan_enable),
		.pixel_ready(pixel_ready),
		.pixel_data(pixel_data),
		.pixel_valid(pixel_valid),
		.line_start(line_start),
		.frame_start(frame_start)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string what, input word_t exp, input word_t act);
		assert (act === exp)
		else begin
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			pass_count++;
			$display("Test %s: ok", cur_test);
		end else begin
			fail_count++;
			$display("Test %s: %0d error(s)", cur_test, test_errors);
		end
	endtask

	function automatic bus_addr_t byte_addr(input int idx, input int tag);
		return bus_addr_t'((tag << TAG_SHIFT) | ((idx % MEM_WORDS) << 2));
	endfunction

	function automatic word_t lane_mask(input sel_t sel);
		word_t m;
		for (int i = 0; i < 4; i++) begin
			m[8*i +: 8] = sel[i] ? 8'hff : 8'h00;
		end
		return m;
	endfunction

	// One access, then one idle cycle so the next one starts with ack low
	task automatic bus_access(input logic we, input bus_addr_t adr, input sel_t sel,
		input word_t wdata, output word_t rdata);
		int waited;
		bit acked;
		waited = 0;
		acked = 0;
		rdata = '0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_sel = sel;
		wb_dat_w = wdata;
		while (!acked && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#2;
			waited++;
			if (wb_ack) begin
				acked = 1;
				rdata = wb_dat_r;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!acked) begin
			$display("Timeout in %s: bus access at %h was never acknowledged", cur_test, adr);
			test_errors++;
		end else begin
			check_value("ack latency", 1, waited);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic write_model(input int idx, input sel_t sel, input word_t data);
		word_t unused;
		model[idx] = (model[idx] & ~lane_mask(sel)) | (data & lane_mask(sel));
		bus_access(1'b1, byte_addr(idx, 0), sel, data, unused);
	endtask

	task automatic read_check(input int idx, input int tag, input sel_t sel, input word_t exp);
		word_t got;
		bus_access(1'b0, byte_addr(idx, tag), sel, '0, got);
		check_value($sformatf("read %0d", idx), exp, got);
	endtask

	// Accepts count words and compares them with the model in raster order
	task automatic collect_stream(input int count, input bit random_ready);
		int got;
		int idle;
		got = 0;
		idle = 0;
		while (got < count && idle < STREAM_TIMEOUT) begin
			pixel_ready = random_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
			if (pixel_valid && pixel_ready) begin
				check_value("pixel_data", model[stream_k % MEM_WORDS], pixel_data);
				check_value("line_start", word_t'(stream_k % LINE_WORDS == 0),
					word_t'(line_start));
				check_value("frame_start", word_t'(stream_k % MEM_WORDS == 0),
					word_t'(frame_start));
				stream_k++;
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			@(posedge clk);
			#2;
		end
		if (got < count) begin
			$display("Timeout in %s: pixel stream stopped after %0d words", cur_test, got);
			test_errors++;
		end
	endtask

	initial begin
		void'($urandom(32'hf96d));
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_dat_w = '0;
		scan_enable = 1'b0;
		pixel_ready = 1'b0;
		pass_count = 0;
		fail_count = 0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		start_test("fill_readback");
		for (int i = 0; i < MEM_WORDS; i++) begin
			model[i] = '0;
			write_model(i, 4'hf, $urandom());
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_check(i, 0, 4'hf, model[i]);
		end
		finish_test();

		start_test("byte_lanes");
		for (int i = 0; i < 300; i++) begin
			write_model($urandom_range(0, MEM_WORDS - 1), sel_t'($urandom()), $urandom());
		end
		for (int i = 0; i < 300; i++) begin
			int idx;
			sel_t sel;
			idx = $urandom_range(0, MEM_WORDS - 1);
			sel = sel_t'($urandom());
			read_check(idx, 0, sel, model[idx] & lane_mask(sel));
		end
		finish_test();

		start_test("window_decode");
		for (int i = 0; i < 100; i++) begin
			int idx;
			int tag;
			word_t unused;
			idx = $urandom_range(0, MEM_WORDS - 1);
			tag = $urandom_range(1, 2047);
			bus_access(1'b1, byte_addr(idx, tag), 4'hf, $urandom(), unused);
			read_check(idx, tag, 4'hf, '0);
			read_check(idx, 0, 4'hf, model[idx]);
		end
		finish_test();

		start_test("scanout_order");
		stream_k = 0;
		pixel_ready = 1'b1;
		scan_enable = 1'b1;
		collect_stream(MEM_WORDS + 40, 1'b0);
		finish_test();

		// Stream keeps running, so word order continues from the last test
		start_test("back_pressure");
		collect_stream(2 * MEM_WORDS, 1'b1);
		finish_test();

		start_test("restart");
		scan_enable = 1'b0;
		pixel_ready = 1'b1;
		for (int i = 0; i < STREAM_TIMEOUT && pixel_valid; i++) begin
			@(posedge clk);
			#2;
		end
		if (pixel_valid) begin
			$display("Timeout in %s: stream did not drain", cur_test);
			test_errors++;
		end
		for (int i = 0; i < 4; i++) begin
			write_model(i, 4'hf, $urandom());
		end
		stream_k = 0;
		scan_enable = 1'b1;
		collect_stream(40, 1'b0);
		scan_enable = 1'b0;
		finish_test();

		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			pass_count, fail_count, DUT.u_chk.error_count);
		if (fail_count == 0 && DUT.u_chk.error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/video_subsystem_chk.sv
`timescale 1ns/1ps

module video_subsystem_chk (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic pixel_valid,
	input logic pixel_ready,
	input video_pkg::word_t pixel_data,
	input logic line_start,
	input logic frame_start
);
	int error_count = 0;

	a_ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else begin
			error_count++;
			$error("wb_ack stayed high for two cycles");
		end

	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			error_count++;
			$error("wb_ack without a preceding bus request");
		end

	// Output word and markers hold under back-pressure
	a_stream_hold: assert property (@(posedge clk) disable iff (rst)
		(pixel_valid && !pixel_ready) |=> pixel_valid && $stable(pixel_data)
			&& $stable(line_start) && $stable(frame_start))
		else begin
			error_count++;
			$error("Pixel stream changed while stalled");
		end

	a_reset_idle: assert property (@(posedge clk) rst |=> !wb_ack && !pixel_valid)
		else begin
			error_count++;
			$error("wb_ack or pixel_valid high after reset");
		end

endmodule

bind video_subsystem video_subsystem_chk u_chk (
	.clk(clk),
	.rst(rst),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.pixel_valid(pixel_valid),
	.pixel_ready(pixel_ready),
	.pixel_data(pixel_data),
	.line_start(line_start),
	.frame_start(frame_start)
);

//--- source/video_subsystem.sv
`timescale 1ns/1ps

module video_subsystem #(
	parameter int BANK_ADDR_BITS = video_pkg::BANK_ADDR_BITS,
	parameter int WINDOW_BASE = video_pkg::WINDOW_BASE,
	parameter int LINE_WORDS = 32,
	parameter int LINE_COUNT = 64
) (
	input logic clk,
	input logic rst,

	// Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input video_pkg::bus_addr_t wb_adr,
	input video_pkg::sel_t wb_sel,
	input video_pkg::word_t wb_dat_w,
	output video_pkg::word_t wb_dat_r,
	output logic wb_ack,

	// Pixel stream
	input logic scan_enable,
	input logic pixel_ready,
	output video_pkg::word_t pixel_data,
	output logic pixel_valid,
	output logic line_start,
	output logic frame_start
);
	import video_pkg::*;

	logic bus_wr_en;
	logic bus_rd_en;
	mem_addr_t bus_addr;
	sel_t bus_wmask;
	word_t bus_wdata;
	word_t bus_rdata;
	mem_addr_t vid_addr;
	word_t vid_rdata;

	wb_mem_port #(
		.BANK_ADDR_BITS(BANK_ADDR_BITS),
		.WINDOW_BASE(WINDOW_BASE)
	) u_wb_mem_port (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.bus_wr_en(bus_wr_en),
		.bus_rd_en(bus_rd_en),
		.bus_addr(bus_addr),
		.bus_wmask(bus_wmask),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata)
	);

	video_memory #(
		.BANK_ADDR_BITS(BANK_ADDR_BITS)
	) u_video_memory (
		.clk(clk),
		.rst(rst),
		.bus_wr_en(bus_wr_en),
		.bus_rd_en(bus_rd_en),
		.bus_addr(bus_addr),
		.bus_wmask(bus_wmask),
		.bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata),
		.vid_addr(vid_addr),
		.vid_rdata(vid_rdata)
	);

	scanout #(
		.LINE_WORDS(LINE_WORDS),
		.LINE_COUNT(LINE_COUNT)
	) u_scanout (
		.clk(clk),
		.rst(rst),
		.scan_enable(scan_enable),
		.pixel_ready(pixel_ready),
		.vid_addr(vid_addr),
		.vid_rdata(vid_rdata),
		.pixel_data(pixel_data),
		.pixel_valid(pixel_valid),
		.line_start(line_start),
		.frame_start(frame_start)
	);

endmodule

//--- source/scanout.sv
`timescale 1ns/1ps

module scanout #(
	parameter int LINE_WORDS = 32,
	parameter int LINE_COUNT = 64
) (
	input logic clk,
	input logic rst,

	input logic scan_enable,
	input logic pixel_ready,

	output video_pkg::mem_addr_t vid_addr,
	input video_pkg::word_t vid_rdata,

	output video_pkg::word_t pixel_data,
	output logic pixel_valid,
	output logic line_start,
	output logic frame_start
);
	import video_pkg::*;

	localparam int FRAME_WORDS = LINE_WORDS * LINE_COUNT;
	localparam int COL_BITS = $clog2(LINE_WORDS);

	typedef logic [COL_BITS-1:0] col_t;

	localparam mem_addr_t LAST_ADDR = mem_addr_t'(FRAME_WORDS - 1);
	localparam col_t LAST_COL = col_t'(LINE_WORDS - 1);

	logic advance;
	logic stage_valid_q;
	logic stage_valid_d;
	mem_addr_t addr_q;
	mem_addr_t addr_d;
	col_t col_q;
	col_t col_d;

	// Output register empty or handing its word over this cycle
	assign advance = !pixel_valid || pixel_ready;

	// The memory reads the next stage address, so a stalled stage keeps its data
	always_comb begin
		stage_valid_d = stage_valid_q;
		addr_d = addr_q;
		col_d = col_q;
		if (advance) begin
			stage_valid_d = scan_enable;
			if (!stage_valid_q) begin
				// Idle stage always restarts at the top of the frame
				addr_d = '0;
				col_d = '0;
			end else begin
				addr_d = (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1;
				col_d = (col_q == LAST_COL) ? '0 : col_q + 1'b1;
			end
		end
	end

	assign vid_addr = addr_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid_q <= 1'b0;
			addr_q <= '0;
			col_q <= '0;
			pixel_valid <= 1'b0;
			line_start <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			stage_valid_q <= stage_valid_d;
			addr_q <= addr_d;
			col_q <= col_d;
			if (advance) begin
				pixel_valid <= stage_valid_q;
				line_start <= stage_valid_q && (col_q == '0);
				frame_start <= stage_valid_q && (addr_q == '0);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && stage_valid_q) begin
			pixel_data <= vid_rdata;
		end
	end

endmodule

//--- source/video_memory.sv
`timescale 1ns/1ps

module video_memory #(
	parameter int BANK_ADDR_BITS = video_pkg::BANK_ADDR_BITS
) (
	input logic clk,
	input logic rst,

	// Bus side, read/write
	input logic bus_wr_en,
	input logic bus_rd_en,
	input video_pkg::mem_addr_t bus_addr,
	input video_pkg::sel_t bus_wmask,
	input video_pkg::word_t bus_wdata,
	output video_pkg::word_t bus_rdata,

	// Video side, read only
	input video_pkg::mem_addr_t vid_addr,
	output video_pkg::word_t vid_rdata
);
	import video_pkg::*;

	typedef logic [BANK_ADDR_BITS-1:0] bank_addr_t;
	typedef logic [BANK_SEL_BITS-1:0] bank_sel_t;

	bank_sel_t bus_bank;
	bank_sel_t vid_bank;
	bank_addr_t bus_offset;
	bank_addr_t vid_offset;

	bank_sel_t bus_bank_q;
	bank_sel_t vid_bank_q;
	logic rd_pending_q;

	word_t rdata_a [NUM_BANKS];
	word_t rdata_b [NUM_BANKS];

	// Bank index sits above the in-bank word address
	assign bus_bank = bus_addr[BANK_ADDR_BITS +: BANK_SEL_BITS];
	assign bus_offset = bus_addr[BANK_ADDR_BITS-1:0];
	assign vid_bank = vid_addr[BANK_ADDR_BITS +: BANK_SEL_BITS];
	assign vid_offset = vid_addr[BANK_ADDR_BITS-1:0];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		// Port a doubles as the write port, so writes and reads share the address
		sram_bank #(
			.BANK_ADDR_BITS(BANK_ADDR_BITS)
		) u_bank (
			.clk(clk),
			.wr_en(bus_wr_en && (bus_bank == bank_sel_t'(b))),
			.wmask(bus_wmask),
			.waddr(bus_offset),
			.wdata(bus_wdata),
			.raddr_a(bus_offset),
			.rdata_a(rdata_a[b]),
			.raddr_b(vid_offset),
			.rdata_b(rdata_b[b])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pending_q <= 1'b0;
		end else begin
			rd_pending_q <= bus_rd_en;
		end
	end

	// Bank indices follow the data through the one-cycle read
	always_ff @(posedge clk) begin
		if (bus_rd_en) begin
			bus_bank_q <= bus_bank;
		end
		vid_bank_q <= vid_bank;
	end

	assign bus_rdata = rd_pending_q ? rdata_a[bus_bank_q] : '0;
	assign vid_rdata = rdata_b[vid_bank_q];

endmodule

//--- source/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
	parameter int BANK_ADDR_BITS = video_pkg::BANK_ADDR_BITS
) (
	input logic clk,

	input logic wr_en,
	input video_pkg::sel_t wmask,
	input logic [BANK_ADDR_BITS-1:0] waddr,
	input video_pkg::word_t wdata,

	input logic [BANK_ADDR_BITS-1:0] raddr_a,
	output video_pkg::word_t rdata_a,
	input logic [BANK_ADDR_BITS-1:0] raddr_b,
	output video_pkg::word_t rdata_b
);
	import video_pkg::*;

	localparam int DEPTH = 2 ** BANK_ADDR_BITS;

	word_t mem [DEPTH];

	// Byte-masked write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (wmask[i]) begin
					mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Both reads see the contents from before a same-cycle write
	always_ff @(posedge clk) begin
		rdata_a <= mem[raddr_a];
		rdata_b <= mem[raddr_b];
	end

endmodule

//--- source/wb_mem_port.sv
`timescale 1ns/1ps

module wb_mem_port #(
	parameter int BANK_ADDR_BITS = video_pkg::BANK_ADDR_BITS,
	parameter int WINDOW_BASE = video_pkg::WINDOW_BASE
) (
	input logic clk,
	input logic rst,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input video_pkg::bus_addr_t wb_adr,
	input video_pkg::sel_t wb_sel,
	input video_pkg::word_t wb_dat_w,
	output logic wb_ack,
	output video_pkg::word_t wb_dat_r,

	output logic bus_wr_en,
	output logic bus_rd_en,
	output video_pkg::mem_addr_t bus_addr,
	output video_pkg::sel_t bus_wmask,
	output video_pkg::word_t bus_wdata,
	input video_pkg::word_t bus_rdata
);
	import video_pkg::*;

	// Byte address layout is tag, bank, word offset, byte offset
	localparam int TAG_LSB = BANK_ADDR_BITS + BANK_SEL_BITS + 2;
	localparam bus_addr_t WINDOW_TAG = bus_addr_t'(WINDOW_BASE);

	logic accept;
	logic in_window;
	logic ack_q;
	logic rd_hit_q;
	sel_t sel_q;

	// A new access is taken only while no acknowledge is pending
	assign accept = wb_cyc && wb_stb && !ack_q;
	assign in_window = (wb_adr >> TAG_LSB) == WINDOW_TAG;

	assign bus_wr_en = accept && wb_we && in_window;
	assign bus_rd_en = accept && !wb_we && in_window;
	assign bus_addr = wb_adr[2 +: BANK_ADDR_BITS + BANK_SEL_BITS];
	assign bus_wmask = wb_sel;
	assign bus_wdata = wb_dat_w;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			rd_hit_q <= 1'b0;
		end else begin
			ack_q <= accept;
			rd_hit_q <= bus_rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sel_q <= wb_sel;
		end
	end

	// Unselected lanes and out-of-window reads return zero
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			wb_dat_r[8*i +: 8] = (rd_hit_q && sel_q[i]) ? bus_rdata[8*i +: 8] : 8'h00;
		end
	end

	assign wb_ack = ack_q;

endmodule

//--- source/video_pkg.sv
package video_pkg;

	// Bus and data widths
	localparam int BUS_ADDR_BITS = 24;
	localparam int WORD_BITS = 32;
	localparam int NUM_LANES = WORD_BITS / 8;

	// Memory geometry
	localparam int BANK_ADDR_BITS = 9;
	localparam int NUM_BANKS = 4;
	localparam int BANK_SEL_BITS = $clog2(NUM_BANKS);
	localparam int MEM_ADDR_BITS = BANK_ADDR_BITS + BANK_SEL_BITS;

	// Tag the bus address bits above the memory must match
	localparam int WINDOW_BASE = 0;

	// Data word for bus, memory and pixel stream
	typedef logic [WORD_BITS-1:0] word_t;

	// Byte lane enables, bit i covers byte i of the word
	typedef logic [NUM_LANES-1:0] sel_t;

	// Wishbone byte address
	typedef logic [BUS_ADDR_BITS-1:0] bus_addr_t;

	// Word address across all banks, bank index on top
	typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

endpackage
